//--- Makefile
TOOL  ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP   ?= gpuBackendTb
FLIST ?= gpuBackend.f
LOG   ?= sim.log
OBJ   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- dv/gpuBackendProps.sv
`timescale 1ns/100ps

module gpuBackendProps (
	input logic                                    clk,
	input logic                                    i_arstN,
	input logic                                    i_pause,
	input logic                                    o_stencilWrite,
	input logic                                    o_pixelInFlight,
	input logic                                    o_writePixelOnNewBlock,
	input logic [gpuBackendPkg::PAIR_ID_W-1:0]     o_stencilPair,
	input logic [1:0]                              o_stencilSelect,
	input logic [gpuBackendPkg::BLOCK_W-1:0]       o_exportedBlock,
	input logic [gpuBackendPkg::BLOCK_PIXELS-1:0]  o_exportedMask
);

	// ----------------------------------------------------------------------
	// Write rules
	// ----------------------------------------------------------------------

	// Paused edges neither write nor touch the cache
	aNoWriteWhilePaused: assert property (@(posedge clk) disable iff (!i_arstN)
		i_pause |=> (!$past(o_stencilWrite) && $stable(o_exportedBlock)
			&& $stable(o_exportedMask)))
		else $error("stencil write or cache change while paused");

	// A write needs a pixel in the pipe and sets the mask of each written side
	aWriteNeedsPixel: assert property (@(posedge clk) disable iff (!i_arstN)
		o_stencilWrite |=> ($past(o_pixelInFlight)
			&& (((o_exportedMask >> (2 * $past(o_stencilPair)))
				& 16'($past(o_stencilSelect))) == 16'($past(o_stencilSelect)))))
		else $error("stencil write did not set its mask bits");

	// Quiet outputs while reset is held
	aQuietInReset: assert property (@(posedge clk)
		!i_arstN |-> (!o_stencilWrite && !o_writePixelOnNewBlock && !o_pixelInFlight))
		else $error("backend outputs active during reset");

endmodule

bind gpuBackend gpuBackendProps u_props (
	.clk(clk), .i_arstN(i_arstN), .i_pause(i_pause), .o_stencilWrite(o_stencilWrite),
	.o_pixelInFlight(o_pixelInFlight), .o_writePixelOnNewBlock(o_writePixelOnNewBlock),
	.o_stencilPair(o_stencilPair), .o_stencilSelect(o_stencilSelect),
	.o_exportedBlock(o_exportedBlock), .o_exportedMask(o_exportedMask)
);

//--- dv/gpuBackendTb.sv
`timescale 1ns/100ps

module gpuBackendTb;

	// Vector file columns
	localparam int cMode = 0, cNb = 1, cX = 2, cY = 3, cRL = 4, cRR = 7;
	localparam int cVL = 10, cVR = 11, cML = 12, cMR = 13;
	localparam int cBgL = 14, cBgR = 15, cExpL = 16, cExpR = 17;

	logic clk, i_arstN, i_noBlend, i_pause, i_validL, i_validR, i_bgMskL, i_bgMskR;
	logic i_flushLastBlock, i_resetPixelMask, i_importBlock;
	gpuBackendPkg::tBlendMode i_blendMode;
	gpuBackendPkg::tBlockCode i_blockFlag, o_saveBlockCode;
	logic [9:0] i_scrX;
	logic [8:0] i_scrY, i_rL, i_gL, i_bL, i_rR, i_gR, i_bR;
	logic [255:0] i_importedBlock, o_exportedBlock;
	logic o_pixelInFlight, o_writePixelOnNewBlock, o_stencilWrite;
	logic [14:0] o_loadAdr, o_saveAdr, o_stencilAdr;
	logic [2:0] o_stencilPair;
	logic [1:0] o_stencilSelect, o_stencilValue;
	logic [15:0] o_exportedMask;

	int vec[32][18];
	int nVec, errors, checks, tests, failedTests, mark, fd, n;
	int seed = 8;
	bit pauseOn;
	bit aborted;
	string line;
	logic [255:0] blk2, blk4, blk;
	logic [15:0] msk2, msk4;
	logic [1:0] sel, val;
	logic [2:0] pairSeen;
	logic [14:0] adrSeen, loadSeen;
	gpuBackendPkg::tBlockCode code;
	logic newBlk;

	gpuBackend #(.pPipeStages(2)) u_dut (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Paused edges must never carry a write
	always @(posedge clk) begin
		if (i_arstN && i_pause && o_stencilWrite) begin
			errors++;
			$display("stencil write seen on a paused edge at %0t", $time);
		end
	end

	// Ends the run once a timeout has been reported
	initial begin
		wait (aborted);
		$display("=== FAIL ===");
		$finish;
	end

	task automatic checkEq(input logic [255:0] got, input logic [255:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %0h exp %0h", $time, msg, got, exp);
		end
	endtask

	task automatic abortRun(input string why);
		$display("%s", why);
		aborted = 1'b1;
		forever @(negedge clk);
	endtask

	task automatic endTest(input string name);
		tests++;
		if (errors != mark) failedTests++;
		$display("test %s %s", name, (errors == mark) ? "passed" : "failed");
		mark = errors;
	endtask

	// ----------------------------------------------------------------------
	// Cycle helpers, all start and end on a falling edge
	// ----------------------------------------------------------------------
	task automatic fallEdge();
		@(negedge clk);
		i_pause = pauseOn && (($random(seed) & 3) == 0);
	endtask

	// Hold driven inputs until an unpaused rising edge takes them
	task automatic passEdge(input string what);
		bit free;
		for (int t = 0; t <= 64; t++) begin
			#1;
			free = !i_pause;
			fallEdge();
			if (free) return;
		end
		abortRun({"timeout waiting for an unpaused edge in ", what});
	endtask

	task automatic idleOp(input logic imp, input logic [255:0] b, input logic rst);
		i_importBlock = imp;
		i_importedBlock = b;
		i_resetPixelMask = rst;
		passEdge("idleOp");
		i_importBlock = 1'b0;
		i_resetPixelMask = 1'b0;
	endtask

	task automatic sendPair(input int i, input gpuBackendPkg::tBlockCode flag);
		i_blockFlag = flag;
		i_scrX = 10'(vec[i][cX]);
		i_scrY = 9'(vec[i][cY]);
		{i_rL, i_gL, i_bL} = {9'(vec[i][cRL]), 9'(vec[i][cRL+1]), 9'(vec[i][cRL+2])};
		{i_rR, i_gR, i_bR} = {9'(vec[i][cRR]), 9'(vec[i][cRR+1]), 9'(vec[i][cRR+2])};
		i_validL = vec[i][cVL][0];
		i_validR = vec[i][cVR][0];
		i_bgMskL = vec[i][cML][0];
		i_bgMskR = vec[i][cMR][0];
		passEdge("sendPair");
		i_validL = 1'b0;
		i_validR = 1'b0;
	endtask

	// Stencil outputs are stable in the low clock phase
	task automatic waitWrite();
		for (int t = 0; t <= 64; t++) begin
			#1;
			if (o_stencilWrite) begin
				sel = o_stencilSelect;
				val = o_stencilValue;
				pairSeen = o_stencilPair;
				adrSeen = o_stencilAdr;
				loadSeen = o_loadAdr;
				code = o_saveBlockCode;
				newBlk = o_writePixelOnNewBlock;
				fallEdge();
				return;
			end
			fallEdge();
		end
		abortRun("timeout waiting for a stencil write");
	endtask

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------
	function automatic int modelComp(int c, int bg, int mode, int nb);
		int f;
		f = ((c > 255) ? 255 : c) >> 3;
		if (nb != 0) return f;
		case (mode)
			0: return (bg + f) / 2;
			1: return (bg + f > 31) ? 31 : bg + f;
			2: return (bg < f) ? 0 : bg - f;
			default: return (bg + f / 4 > 31) ? 31 : bg + f / 4;
		endcase
	endfunction

	function automatic logic [15:0] modelPix(int i, int side);
		int c, bg, r, g, b;
		c = side ? cRR : cRL;
		bg = side ? vec[i][cBgR] : vec[i][cBgL];
		r = modelComp(vec[i][c], bg & 31, vec[i][cMode], vec[i][cNb]);
		g = modelComp(vec[i][c+1], (bg >> 5) & 31, vec[i][cMode], vec[i][cNb]);
		b = modelComp(vec[i][c+2], (bg >> 10) & 31, vec[i][cMode], vec[i][cNb]);
		return 16'((vec[i][side ? cMR : cML] << 15) | (b << 10) | (g << 5) | r);
	endfunction

	// Y above X bits 9..4
	function automatic logic [14:0] blockAdrOf(int i);
		return 15'((vec[i][cY] << 6) | (vec[i][cX] >> 4));
	endfunction

	// Fill value mixes the whole pixel index
	function automatic logic [255:0] fillBlock();
		logic [255:0] b;
		for (int i = 0; i < 16; i++) b[i*16 +: 16] = 16'hA53C ^ 16'(i * 16'h0F1D);
		return b;
	endfunction

	task automatic runNoBlendSet(output logic [255:0] outBlk, output logic [15:0] outMsk);
		logic [255:0] expBlk;
		logic [15:0] expMsk;
		int p;
		expBlk = fillBlock();
		expMsk = '0;
		idleOp(1'b1, expBlk, 1'b1);
		for (int i = 0; i < nVec; i++) begin
			if (vec[i][cNb] != 0) begin
				i_noBlend = 1'b1;
				sendPair(i, gpuBackendPkg::bcNone);
				waitWrite();
				p = (vec[i][cX] >> 1) & 7;
				checkEq(256'(sel), 256'({vec[i][cVR][0], vec[i][cVL][0]}), "stencil select");
				checkEq(256'(val), 256'({vec[i][cVR][0] & vec[i][cMR][0],
					vec[i][cVL][0] & vec[i][cML][0]}), "stencil value");
				checkEq(256'(pairSeen), 256'(p), "stencil pair");
				checkEq(256'(adrSeen), 256'(blockAdrOf(i)), "stencil address");
				checkEq(256'(loadSeen), 256'(blockAdrOf(i)), "load address");
				if (vec[i][cVL] != 0) begin
					expBlk[p*32 +: 16] = 16'(vec[i][cExpL]);
					expMsk[p*2] = 1'b1;
				end
				if (vec[i][cVR] != 0) begin
					expBlk[p*32+16 +: 16] = 16'(vec[i][cExpR]);
					expMsk[p*2+1] = 1'b1;
				end
			end
		end
		#1;
		checkEq(o_exportedBlock, expBlk, "no-blend block");
		checkEq(256'(o_exportedMask), 256'(expMsk), "no-blend mask");
		outBlk = o_exportedBlock;
		outMsk = o_exportedMask;
		fallEdge();
	endtask

	task automatic codeCase(input int i, input gpuBackendPkg::tBlockCode flag, input logic nb,
		input logic flush, input gpuBackendPkg::tBlockCode exp);
		i_noBlend = nb;
		i_flushLastBlock = flush;
		sendPair(i, flag);
		waitWrite();
		i_flushLastBlock = 1'b0;
		#1;
		checkEq(256'(code), 256'(exp), "block code");
		checkEq(256'(newBlk), 256'(exp != gpuBackendPkg::bcNone), "write on new block");
		checkEq(256'(o_saveAdr), 256'(blockAdrOf(i)), "save address");
		fallEdge();
	endtask

	initial begin
		{i_noBlend, i_pause, i_validL, i_validR, i_bgMskL, i_bgMskR} = '0;
		{i_flushLastBlock, i_resetPixelMask, i_importBlock} = '0;
		{i_scrX, i_scrY, i_rL, i_gL, i_bL, i_rR, i_gR, i_bR} = '0;
		i_blendMode = gpuBackendPkg::bmAvg;
		i_blockFlag = gpuBackendPkg::bcNone;
		i_importedBlock = '0;
		i_arstN = 1'b0;
		fd = $fopen("dv/gpuBackendVectors.txt", "r");
		if (fd == 0) abortRun("cannot open the vector file");
		while (!$feof(fd) && nVec < 32) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %h %h %h %h",
				vec[nVec][0], vec[nVec][1], vec[nVec][2], vec[nVec][3], vec[nVec][4],
				vec[nVec][5], vec[nVec][6], vec[nVec][7], vec[nVec][8], vec[nVec][9],
				vec[nVec][10], vec[nVec][11], vec[nVec][12], vec[nVec][13],
				vec[nVec][14], vec[nVec][15], vec[nVec][16], vec[nVec][17]);
			if (line.len() > 0 && line.getc(0) != "#" && n == 18) nVec++;
		end
		$fclose(fd);
		repeat (16) @(posedge clk);
		fallEdge();
		i_arstN = 1'b1;
		#1;
		checkEq(256'({o_stencilWrite, o_pixelInFlight, o_writePixelOnNewBlock}), '0, "reset flags");
		checkEq(256'(o_saveBlockCode), 256'(gpuBackendPkg::bcNone), "reset code");
		checkEq(256'(o_exportedMask), '0, "reset mask");
		fallEdge();
		endTest("reset");
		runNoBlendSet(blk2, msk2);
		endTest("no-blend");
		for (int i = 0; i < nVec; i++) begin
			int p;
			p = (vec[i][cX] >> 1) & 7;
			blk = fillBlock();
			blk[p*32 +: 16] = 16'(vec[i][cBgL]);
			blk[p*32+16 +: 16] = 16'(vec[i][cBgR]);
			idleOp(1'b1, blk, 1'b1);
			i_noBlend = (vec[i][cNb] != 0);
			i_blendMode = gpuBackendPkg::tBlendMode'(vec[i][cMode][1:0]);
			sendPair(i, gpuBackendPkg::bcNone);
			waitWrite();
			#1;
			if (vec[i][cVL] != 0) checkEq(256'(modelPix(i, 0)), 256'(vec[i][cExpL]), "model L");
			if (vec[i][cVR] != 0) checkEq(256'(modelPix(i, 1)), 256'(vec[i][cExpR]), "model R");
			checkEq(256'(o_exportedBlock[p*32 +: 16]),
				256'((vec[i][cVL] != 0) ? vec[i][cExpL] : vec[i][cBgL]), "blend L");
			checkEq(256'(o_exportedBlock[p*32+16 +: 16]),
				256'((vec[i][cVR] != 0) ? vec[i][cExpR] : vec[i][cBgR]), "blend R");
			fallEdge();
		end
		endTest("blend");
		pauseOn = 1'b1;
		runNoBlendSet(blk4, msk4);
		pauseOn = 1'b0;
		checkEq(blk4, blk2, "paused block");
		checkEq(256'(msk4), 256'(msk2), "paused mask");
		endTest("pause");
		i_blendMode = gpuBackendPkg::bmAvg;
		codeCase(8, gpuBackendPkg::bcFirst, 1'b0, 1'b0, gpuBackendPkg::bcFirst);
		codeCase(9, gpuBackendPkg::bcFirst, 1'b1, 1'b0, gpuBackendPkg::bcNone);
		codeCase(10, gpuBackendPkg::bcNext, 1'b0, 1'b1, gpuBackendPkg::bcLast);
		codeCase(11, gpuBackendPkg::bcNone, 1'b0, 1'b0, gpuBackendPkg::bcNone);
		codeCase(12, gpuBackendPkg::bcFirst, 1'b1, 1'b1, gpuBackendPkg::bcLast);
		endTest("block code");
		// Known block with pair 0 written, then the mask cleared on an idle edge
		blk = fillBlock();
		idleOp(1'b1, blk, 1'b0);
		i_noBlend = 1'b1;
		sendPair(0, gpuBackendPkg::bcNone);
		waitWrite();
		blk[15:0] = 16'(vec[0][cExpL]);
		blk[31:16] = 16'(vec[0][cExpR]);
		#1;
		checkEq(256'(o_exportedMask[1:0]), 256'(2'b11), "mask before clear");
		fallEdge();
		idleOp(1'b0, '0, 1'b1);
		#1;
		checkEq(256'(o_exportedMask), '0, "cleared mask");
		checkEq(o_exportedBlock, blk, "block after mask clear");
		endTest("mask reset");
		$display("tests %0d failed %0d checks %0d errors %0d", tests, failedTests, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- dv/gpuBackendVectors.txt
# mode noBlend x y rL gL bL rR gR bR validL validR mskL mskR (decimal)
# bgL bgR expL expR (hex halfwords, exp only meaningful for a valid side)
0 1 0 5 8 16 24 300 0 255 1 1 1 0 0000 0000 8c41 7c1f
0 1 2 5 255 255 255 0 0 0 1 0 0 1 0000 0000 7fff 0000
0 1 4 5 0 0 0 40 80 120 0 1 0 1 0000 0000 0000 bd45
0 1 6 5 511 256 7 100 200 150 1 1 0 1 0000 0000 03ff cb2c
0 1 8 5 0 0 0 64 128 192 1 1 1 0 0000 0000 8000 6208
0 1 10 5 33 66 99 33 66 99 1 1 0 1 0000 0000 3104 b104
0 1 12 5 248 247 246 0 0 0 1 0 0 0 0000 0000 7bdf 0000
0 1 14 5 0 0 0 16 16 16 0 1 0 1 0000 0000 0000 8842
0 0 20 7 80 0 300 0 8 255 1 1 1 0 7a8a ffff f94a 7e0f
0 0 100 200 255 255 255 0 0 0 1 0 0 0 0000 1234 3def 0000
1 0 36 1 96 80 8 16 16 300 1 1 1 0 00b4 0c41 85ff 7c83
1 0 1022 511 8 0 0 0 0 0 1 1 1 1 7fff 0000 ffff 8000
2 0 50 3 80 48 300 8 0 0 1 1 0 1 7cb4 8000 000a 8000
2 0 64 64 0 0 0 0 0 0 1 0 0 0 7fff 4321 7fff 0000
3 0 70 9 255 100 40 32 24 300 1 1 1 0 038a 401f 87f1 5c1f
3 0 2 0 24 32 128 0 0 0 1 0 0 0 0000 0000 1020 0000

//--- gpuBackend.f
src/gpuBackendPkg.sv
src/pixelPipe.sv
src/blendUnit.sv
src/bgBlockCache.sv
src/gpuBackend.sv
dv/gpuBackendProps.sv
dv/gpuBackendTb.sv

//--- src/bgBlockCache.sv
`timescale 1ns/100ps

module bgBlockCache (
	input  logic                                     clk,
	input  logic                                     i_arstN,
	input  logic                                     i_pause,
	input  logic                                     i_noBlend,
	input  logic                                     i_flushLastBlock,
	// Stage-out pair
	input  gpuBackendPkg::tBlockCode                 i_blockFlag,
	input  logic [gpuBackendPkg::SCR_X_W-1:0]        i_scrX,
	input  logic [gpuBackendPkg::SCR_Y_W-1:0]        i_scrY,
	input  logic                                     i_validL,
	input  logic                                     i_validR,
	input  logic                                     i_bgMskL,
	input  logic                                     i_bgMskR,
	// Blended pixels to store
	input  logic [gpuBackendPkg::PIXEL_W-1:0]        i_pixelL,
	input  logic [gpuBackendPkg::PIXEL_W-1:0]        i_pixelR,
	// Block management
	input  logic                                     i_resetPixelMask,
	input  logic                                     i_importBlock,
	input  logic [gpuBackendPkg::BLOCK_W-1:0]        i_importedBlock,
	// Background of the addressed pair, right in the upper half
	output logic [2*gpuBackendPkg::PIXEL_W-1:0]      o_pairBg,
	// Stencil write port
	output logic                                     o_stencilWrite,
	output logic [gpuBackendPkg::BLOCK_ADR_W-1:0]    o_stencilAdr,
	output logic [gpuBackendPkg::PAIR_ID_W-1:0]      o_stencilPair,
	output logic [1:0]                               o_stencilSelect,
	output logic [1:0]                               o_stencilValue,
	// Memory side
	output logic [gpuBackendPkg::BLOCK_ADR_W-1:0]    o_loadAdr,
	output logic [gpuBackendPkg::BLOCK_ADR_W-1:0]    o_saveAdr,
	output gpuBackendPkg::tBlockCode                 o_saveBlockCode,
	output logic                                     o_writePixelOnNewBlock,
	output logic [gpuBackendPkg::BLOCK_W-1:0]        o_exportedBlock,
	output logic [gpuBackendPkg::BLOCK_PIXELS-1:0]   o_exportedMask
);

	localparam int cPixW = gpuBackendPkg::PIXEL_W;

	logic [gpuBackendPkg::BLOCK_W-1:0]       blockQ;
	logic [gpuBackendPkg::BLOCK_PIXELS-1:0]  maskQ;
	logic [gpuBackendPkg::BLOCK_ADR_W-1:0]   lastAdrQ;

	logic [gpuBackendPkg::PAIR_ID_W-1:0]     pairId;
	logic [gpuBackendPkg::BLOCK_ADR_W-1:0]   blockAdr;
	logic                                    writeEn;
	gpuBackendPkg::tBlockCode                flagAdj;
	gpuBackendPkg::tBlockCode                blockCode;

	// ----------------------------------------------------------------------
	// Addressing
	// ----------------------------------------------------------------------

	// Pair inside the block from X bits 3..1
	assign pairId = i_scrX[3:1];
	assign blockAdr = {i_scrY, i_scrX[gpuBackendPkg::SCR_X_W-1:4]};

	// Read both halfwords of the addressed pair
	assign o_pairBg = blockQ[pairId*2*cPixW +: 2*cPixW];

	// Textures are gone so only validity and pause gate a write
	assign writeEn = !i_pause && (i_validL || i_validR);

	// ----------------------------------------------------------------------
	// Block, mask and last write address
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			blockQ   <= '0;
			maskQ    <= '0;
			lastAdrQ <= '0;
		end else if (writeEn) begin
			lastAdrQ <= blockAdr;
			if (i_validL) begin
				blockQ[pairId*2*cPixW +: cPixW] <= i_pixelL;
				maskQ[pairId*2] <= 1'b1;
			end
			if (i_validR) begin
				blockQ[(pairId*2+1)*cPixW +: cPixW] <= i_pixelR;
				maskQ[pairId*2+1] <= 1'b1;
			end
		end else if (!i_pause) begin
			// Import and mask clear only on an unpaused edge with no write
			if (i_importBlock) begin
				blockQ <= i_importedBlock;
			end
			if (i_resetPixelMask) begin
				maskQ <= '0;
			end
		end
	end

	// Stencil port mirrors the write
	assign o_stencilWrite = writeEn;
	assign o_stencilAdr = blockAdr;
	assign o_stencilPair = pairId;
	assign o_stencilSelect = {i_validR, i_validL};
	assign o_stencilValue = {i_bgMskR & i_validR, i_bgMskL & i_validL};

	// ----------------------------------------------------------------------
	// Block operation code
	// ----------------------------------------------------------------------

	// No background load for a first block without blending
	// Flush still forces the last block code
	always_comb begin
		if (i_blockFlag == gpuBackendPkg::bcFirst && i_noBlend) begin
			flagAdj = gpuBackendPkg::bcNone;
		end else begin
			flagAdj = i_blockFlag;
		end
		blockCode = gpuBackendPkg::tBlockCode'(flagAdj | {2{i_flushLastBlock}});
	end

	assign o_saveBlockCode = blockCode;
	assign o_writePixelOnNewBlock = (blockCode != gpuBackendPkg::bcNone);
	assign o_loadAdr = blockAdr;
	assign o_saveAdr = lastAdrQ;
	assign o_exportedBlock = blockQ;
	assign o_exportedMask = maskQ;

endmodule

//--- src/blendUnit.sv
`timescale 1ns/100ps

module blendUnit (
	input  gpuBackendPkg::tBlendMode                i_blendMode,
	input  logic                                    i_noBlend,
	// Gouraud colour, may overshoot 255
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]    i_r,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]    i_g,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]    i_b,
	input  logic                                    i_bgMsk,
	// Background pixel from the block cache
	input  logic [gpuBackendPkg::PIXEL_W-1:0]       i_bgPixel,
	output logic [gpuBackendPkg::PIXEL_W-1:0]       o_pixel
);

	localparam int cInW = gpuBackendPkg::COLOR_IN_W;
	localparam int cCompW = gpuBackendPkg::COMP_W;

	logic [cCompW-1:0] rOut;
	logic [cCompW-1:0] gOut;
	logic [cCompW-1:0] bOut;

	// ----------------------------------------------------------------------
	// One channel: saturate, convert, then blend with background
	// ----------------------------------------------------------------------
	function automatic logic [cCompW-1:0] blendComp(
		input logic [cInW-1:0]           fIn,
		input logic [cCompW-1:0]         bg,
		input gpuBackendPkg::tBlendMode  mode,
		input logic                      noBlend
	);
		logic [cCompW-1:0] fg;
		logic [cCompW:0]   sum;
		logic [cCompW:0]   diff;
		logic [cCompW-1:0] res;

		// Overshoot clamps to 255, then the top five bits remain
		fg = fIn[cInW-1] ? {cCompW{1'b1}} : fIn[cInW-2 -: cCompW];
		sum = '0;
		diff = '0;
		case (mode)
			gpuBackendPkg::bmAvg: begin
				sum = {1'b0, bg} + {1'b0, fg};
				res = sum[cCompW:1];
			end
			gpuBackendPkg::bmAdd: begin
				sum = {1'b0, bg} + {1'b0, fg};
				res = sum[cCompW] ? {cCompW{1'b1}} : sum[cCompW-1:0];
			end
			gpuBackendPkg::bmSub: begin
				// Borrow out means the result went below zero
				diff = {1'b0, bg} - {1'b0, fg};
				res = diff[cCompW] ? '0 : diff[cCompW-1:0];
			end
			default: begin
				// Add a quarter of the foreground
				sum = {1'b0, bg} + {3'b000, fg[cCompW-1:2]};
				res = sum[cCompW] ? {cCompW{1'b1}} : sum[cCompW-1:0];
			end
		endcase
		return noBlend ? fg : res;
	endfunction

	assign rOut = blendComp(i_r, i_bgPixel[4:0], i_blendMode, i_noBlend);
	assign gOut = blendComp(i_g, i_bgPixel[9:5], i_blendMode, i_noBlend);
	assign bOut = blendComp(i_b, i_bgPixel[14:10], i_blendMode, i_noBlend);

	// Mask bit comes from the incoming pixel
	assign o_pixel = {i_bgMsk, bOut, gOut, rOut};

endmodule

//--- src/gpuBackend.sv
`timescale 1ns/100ps

module gpuBackend #(
	parameter int pPipeStages = 2
) (
	input  logic                                     clk,
	input  logic                                     i_arstN,
	// Setup
	input  gpuBackendPkg::tBlendMode                 i_blendMode,
	input  logic                                     i_noBlend,
	input  logic                                     i_pause,
	// Pixel pair
	input  gpuBackendPkg::tBlockCode                 i_blockFlag,
	input  logic [gpuBackendPkg::SCR_X_W-1:0]        i_scrX,
	input  logic [gpuBackendPkg::SCR_Y_W-1:0]        i_scrY,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]     i_rL,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]     i_gL,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]     i_bL,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]     i_rR,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]     i_gR,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]     i_bR,
	input  logic                                     i_validL,
	input  logic                                     i_validR,
	input  logic                                     i_bgMskL,
	input  logic                                     i_bgMskR,
	// Block control
	input  logic                                     i_flushLastBlock,
	input  logic                                     i_resetPixelMask,
	input  logic                                     i_importBlock,
	input  logic [gpuBackendPkg::BLOCK_W-1:0]        i_importedBlock,
	output logic                                     o_pixelInFlight,
	output logic                                     o_writePixelOnNewBlock,
	output gpuBackendPkg::tBlockCode                 o_saveBlockCode,
	output logic [gpuBackendPkg::BLOCK_ADR_W-1:0]    o_loadAdr,
	output logic [gpuBackendPkg::BLOCK_ADR_W-1:0]    o_saveAdr,
	// Stencil write port
	output logic                                     o_stencilWrite,
	output logic [gpuBackendPkg::BLOCK_ADR_W-1:0]    o_stencilAdr,
	output logic [gpuBackendPkg::PAIR_ID_W-1:0]      o_stencilPair,
	output logic [1:0]                               o_stencilSelect,
	output logic [1:0]                               o_stencilValue,
	output logic [gpuBackendPkg::BLOCK_W-1:0]        o_exportedBlock,
	output logic [gpuBackendPkg::BLOCK_PIXELS-1:0]   o_exportedMask
);

	localparam int cPixW = gpuBackendPkg::PIXEL_W;
	localparam int cColW = gpuBackendPkg::COLOR_IN_W;

	// Stage-out pair
	gpuBackendPkg::tBlockCode               soFlag;
	logic [gpuBackendPkg::SCR_X_W-1:0]      soScrX;
	logic [gpuBackendPkg::SCR_Y_W-1:0]      soScrY;
	logic [cColW-1:0]                       soRL, soGL, soBL;
	logic [cColW-1:0]                       soRR, soGR, soBR;
	logic                                   soValidL, soValidR;
	logic                                   soMskL, soMskR;

	// Background pair and blended results
	logic [2*cPixW-1:0]                     pairBg;
	logic [cPixW-1:0]                       bgL, bgR;
	logic [cPixW-1:0]                       pixelL, pixelR;

	assign bgL = pairBg[cPixW-1:0];
	assign bgR = pairBg[2*cPixW-1:cPixW];

	pixelPipe #(.pPipeStages(pPipeStages)) u_pipe (
		.clk(clk), .i_arstN(i_arstN), .i_pause(i_pause),
		.i_blockFlag(i_blockFlag), .i_scrX(i_scrX), .i_scrY(i_scrY),
		.i_rL(i_rL), .i_gL(i_gL), .i_bL(i_bL), .i_rR(i_rR), .i_gR(i_gR), .i_bR(i_bR),
		.i_validL(i_validL), .i_validR(i_validR), .i_bgMskL(i_bgMskL), .i_bgMskR(i_bgMskR),
		.o_pixelInFlight(o_pixelInFlight), .o_blockFlag(soFlag),
		.o_scrX(soScrX), .o_scrY(soScrY),
		.o_rL(soRL), .o_gL(soGL), .o_bL(soBL), .o_rR(soRR), .o_gR(soGR), .o_bR(soBR),
		.o_validL(soValidL), .o_validR(soValidR), .o_bgMskL(soMskL), .o_bgMskR(soMskR)
	);

	// Even X pixel
	blendUnit u_blendL (
		.i_blendMode(i_blendMode), .i_noBlend(i_noBlend),
		.i_r(soRL), .i_g(soGL), .i_b(soBL), .i_bgMsk(soMskL),
		.i_bgPixel(bgL), .o_pixel(pixelL)
	);

	// Odd X pixel
	blendUnit u_blendR (
		.i_blendMode(i_blendMode), .i_noBlend(i_noBlend),
		.i_r(soRR), .i_g(soGR), .i_b(soBR), .i_bgMsk(soMskR),
		.i_bgPixel(bgR), .o_pixel(pixelR)
	);

	bgBlockCache u_cache (
		.clk(clk), .i_arstN(i_arstN), .i_pause(i_pause), .i_noBlend(i_noBlend),
		.i_flushLastBlock(i_flushLastBlock), .i_blockFlag(soFlag),
		.i_scrX(soScrX), .i_scrY(soScrY), .i_validL(soValidL), .i_validR(soValidR),
		.i_bgMskL(soMskL), .i_bgMskR(soMskR), .i_pixelL(pixelL), .i_pixelR(pixelR),
		.i_resetPixelMask(i_resetPixelMask), .i_importBlock(i_importBlock),
		.i_importedBlock(i_importedBlock), .o_pairBg(pairBg),
		.o_stencilWrite(o_stencilWrite), .o_stencilAdr(o_stencilAdr),
		.o_stencilPair(o_stencilPair), .o_stencilSelect(o_stencilSelect),
		.o_stencilValue(o_stencilValue), .o_loadAdr(o_loadAdr), .o_saveAdr(o_saveAdr),
		.o_saveBlockCode(o_saveBlockCode), .o_writePixelOnNewBlock(o_writePixelOnNewBlock),
		.o_exportedBlock(o_exportedBlock), .o_exportedMask(o_exportedMask)
	);

endmodule

//--- src/gpuBackendPkg.sv
package gpuBackendPkg;

	// ----------------------------------------------------------------------
	// Pixel and colour widths
	// ----------------------------------------------------------------------

	// Gouraud channel may overshoot 255 so it carries one extra bit
	localparam int COLOR_IN_W = 9;
	localparam int COMP_W = 5;
	// Red in 4..0, green in 9..5, blue in 14..10, mask in 15
	localparam int PIXEL_W = 16;

	// ----------------------------------------------------------------------
	// Background block geometry
	// ----------------------------------------------------------------------

	localparam int BLOCK_PIXELS = 16;
	localparam int PAIRS_PER_BLOCK = 8;
	localparam int PAIR_ID_W = 3;
	localparam int BLOCK_W = BLOCK_PIXELS * PIXEL_W;

	// Screen coordinates
	localparam int SCR_X_W = 10;
	localparam int SCR_Y_W = 9;
	// Block address is Y followed by X bits 9..4
	localparam int BLOCK_ADR_W = SCR_Y_W + SCR_X_W - 4;

	// Semi-transparency modes
	typedef enum logic [1:0] {
		bmAvg,
		bmAdd,
		bmSub,
		bmAddQuarter
	} tBlendMode;

	// Block operation toward memory, also the incoming block flag
	typedef enum logic [1:0] {
		bcNone  = 2'b00,
		bcFirst = 2'b01,
		bcNext  = 2'b10,
		bcLast  = 2'b11
	} tBlockCode;

endpackage

//--- src/pixelPipe.sv
`timescale 1ns/100ps

module pixelPipe #(
	parameter int pPipeStages = 2
) (
	input  logic                                   clk,
	input  logic                                   i_arstN,
	input  logic                                   i_pause,
	// Pair entering stage 0
	input  gpuBackendPkg::tBlockCode               i_blockFlag,
	input  logic [gpuBackendPkg::SCR_X_W-1:0]      i_scrX,
	input  logic [gpuBackendPkg::SCR_Y_W-1:0]      i_scrY,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]   i_rL,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]   i_gL,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]   i_bL,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]   i_rR,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]   i_gR,
	input  logic [gpuBackendPkg::COLOR_IN_W-1:0]   i_bR,
	input  logic                                   i_validL,
	input  logic                                   i_validR,
	input  logic                                   i_bgMskL,
	input  logic                                   i_bgMskR,
	// Stage-out pair
	output logic                                   o_pixelInFlight,
	output gpuBackendPkg::tBlockCode               o_blockFlag,
	output logic [gpuBackendPkg::SCR_X_W-1:0]      o_scrX,
	output logic [gpuBackendPkg::SCR_Y_W-1:0]      o_scrY,
	output logic [gpuBackendPkg::COLOR_IN_W-1:0]   o_rL,
	output logic [gpuBackendPkg::COLOR_IN_W-1:0]   o_gL,
	output logic [gpuBackendPkg::COLOR_IN_W-1:0]   o_bL,
	output logic [gpuBackendPkg::COLOR_IN_W-1:0]   o_rR,
	output logic [gpuBackendPkg::COLOR_IN_W-1:0]   o_gR,
	output logic [gpuBackendPkg::COLOR_IN_W-1:0]   o_bR,
	output logic                                   o_validL,
	output logic                                   o_validR,
	output logic                                   o_bgMskL,
	output logic                                   o_bgMskR
);

	localparam int cLast = pPipeStages - 1;

	// One entry per stage, index 0 is closest to the input
	gpuBackendPkg::tBlockCode                  flagQ  [pPipeStages];
	logic                                      validLQ[pPipeStages];
	logic                                      validRQ[pPipeStages];
	logic [gpuBackendPkg::SCR_X_W-1:0]         scrXQ  [pPipeStages];
	logic [gpuBackendPkg::SCR_Y_W-1:0]         scrYQ  [pPipeStages];
	// Colour triplets packed as {r, g, b}
	logic [3*gpuBackendPkg::COLOR_IN_W-1:0]    rgbLQ  [pPipeStages];
	logic [3*gpuBackendPkg::COLOR_IN_W-1:0]    rgbRQ  [pPipeStages];
	logic                                      mskLQ  [pPipeStages];
	logic                                      mskRQ  [pPipeStages];

	// ----------------------------------------------------------------------
	// Control chain with reset
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_arstN) begin
		if (!i_arstN) begin
			for (int s = 0; s < pPipeStages; s++) begin
				flagQ[s]   <= gpuBackendPkg::bcNone;
				validLQ[s] <= 1'b0;
				validRQ[s] <= 1'b0;
			end
		end else if (!i_pause) begin
			flagQ[0]   <= i_blockFlag;
			validLQ[0] <= i_validL;
			validRQ[0] <= i_validR;
			for (int s = 1; s < pPipeStages; s++) begin
				flagQ[s]   <= flagQ[s-1];
				validLQ[s] <= validLQ[s-1];
				validRQ[s] <= validRQ[s-1];
			end
		end
	end

	// Payload chain, only moves when unpaused
	always_ff @(posedge clk) begin
		if (!i_pause) begin
			// Right X is implied by the pair so only the even X is kept
			scrXQ[0] <= {i_scrX[gpuBackendPkg::SCR_X_W-1:1], 1'b0};
			scrYQ[0] <= i_scrY;
			rgbLQ[0] <= {i_rL, i_gL, i_bL};
			rgbRQ[0] <= {i_rR, i_gR, i_bR};
			mskLQ[0] <= i_bgMskL;
			mskRQ[0] <= i_bgMskR;
			for (int s = 1; s < pPipeStages; s++) begin
				scrXQ[s] <= scrXQ[s-1];
				scrYQ[s] <= scrYQ[s-1];
				rgbLQ[s] <= rgbLQ[s-1];
				rgbRQ[s] <= rgbRQ[s-1];
				mskLQ[s] <= mskLQ[s-1];
				mskRQ[s] <= mskRQ[s-1];
			end
		end
	end

	// Any valid pixel in any stage
	always_comb begin
		o_pixelInFlight = 1'b0;
		for (int s = 0; s < pPipeStages; s++) begin
			o_pixelInFlight = o_pixelInFlight | validLQ[s] | validRQ[s];
		end
	end

	assign o_blockFlag = flagQ[cLast];
	assign o_validL = validLQ[cLast];
	assign o_validR = validRQ[cLast];
	assign o_scrX = scrXQ[cLast];
	assign o_scrY = scrYQ[cLast];
	assign {o_rL, o_gL, o_bL} = rgbLQ[cLast];
	assign {o_rR, o_gR, o_bR} = rgbRQ[cLast];
	assign o_bgMskL = mskLQ[cLast];
	assign o_bgMskR = mskRQ[cLast];

endmodule
